// File: mem_subsys_top.f
+incdir+common
common/mem_pkg.sv
rtl/channel_arb.sv
ddr_ctrl/mem_bank.sv
ddr_ctrl/ddr_ctrl.sv
ddr_ctrl/read_gather.sv
rtl/mem_subsys_top.sv
test/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_mem_subsys -f mem_subsys_top.f -o tb_mem_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0

// File: test/tb_mem_subsys.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_subsys import mem_pkg::*; ();

    localparam int LATENCY    = 3;                          // Acceptance edge to channel done
    localparam int DEPTH      = `DDR_LANES << `DDR_ROW_BITS; // Words before addresses alias
    localparam int TIMEOUT    = 20;                         // Cycles allowed per wait
    localparam int KIND_LOAD  = 0;                          // Kind code is also its grant bit
    localparam int KIND_STORE = 1;
    localparam int KIND_PC    = 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       pc_index_valid;
    ddr_index_t pc_index;
    logic       opstore_index_valid;
    ddr_index_t opstore_index;
    word_t      opstore_write_mask;
    word_t      opstore_write_data;
    logic       opload_index_valid;
    ddr_index_t opload_index;
    logic       pc_index_ready;
    logic       opstore_index_ready;
    logic       opload_index_ready;
    line_t      pc_read_inst;
    word_t      opload_read_data;
    logic       pc_operation_done;
    logic       opstore_operation_done;
    logic       opload_operation_done;

    word_t ref_mem [DEPTH];                 // Reference memory that starts cleared like the banks
    int    exp_kind [$];                    // Requests in flight with the oldest first
    line_t exp_data [$];                    // Expected read result with a load word in low bits
    int    exp_cycle [$];                   // Cycle count right after the accepting edge
    int    cycle_cnt = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    test_fails = 0;                  // fail_cnt when the current test began

    always #20 clk = ~clk;                  // 40 ns period
    always @(posedge clk) cycle_cnt++;

    mem_subsys_top mem_subsys_top_inst (.*);

    task automatic check_value(string name, line_t got, line_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt + 1);
        $display("=== FAIL ===");
        $finish;
    endtask

    // Model of one accepted request that updates the store data or returns the read result
    function automatic line_t model_access(int kind, ddr_index_t idx, word_t mask, word_t data);
        int    addr;
        int    base;
        line_t result;
        addr   = int'(idx) % DEPTH;                           // Upper index bits alias
        base   = addr - (addr % `DDR_LANES);                  // Aligned start of the line
        result = '0;
        if (kind == KIND_STORE) begin
            for (int b = 0; b < 64; b++) begin
                if (mask[b])
                    ref_mem[addr][b] = data[b];               // Only masked bits take new data
            end
        end else if (kind == KIND_LOAD) begin
            result[63:0] = ref_mem[addr];
        end else begin
            for (int i = 0; i < `DDR_LANES; i++)
                result[i*64 +: 64] = ref_mem[base + i];       // Lane 0 in the low word
        end
        return result;
    endfunction

    // Done pulses checked against the oldest request and then the ready strobes
    always @(negedge clk) begin : compare
        int    kind;
        line_t data;
        if (!rst && (pc_operation_done || opstore_operation_done || opload_operation_done)) begin
            if (exp_kind.size() == 0) begin
                $display("A done pulse arrived with no request in flight");
                fail_cnt++;
            end else begin
                kind = exp_kind.pop_front();
                data = exp_data.pop_front();
                check_value("pc_operation_done", pc_operation_done, kind == KIND_PC);
                check_value("opstore_operation_done", opstore_operation_done, kind == KIND_STORE);
                check_value("opload_operation_done", opload_operation_done, kind == KIND_LOAD);
                check_value("done latency", cycle_cnt - exp_cycle.pop_front(), LATENCY);
                if (kind == KIND_PC)
                    check_value("pc_read_inst", pc_read_inst, data);
                else if (kind == KIND_LOAD)
                    check_value("opload_read_data", opload_read_data, data[63:0]);
            end
        end
        #1;                                                   // Readies settle after the drive
        if (!rst && (pc_index_ready || opstore_index_ready || opload_index_ready) &&
            (!mem_subsys_top_inst.ddr_ready ||
             $countones({pc_index_ready, opstore_index_ready, opload_index_ready}) > 1)) begin
            $display("A ready rose while busy or together with another ready");
            fail_cnt++;
        end
    end

    task automatic drive_request(int kind, ddr_index_t idx, word_t mask, word_t data);
        if (kind == KIND_STORE) begin
            opstore_index_valid = 1'b1;
            opstore_index       = idx;
            opstore_write_mask  = mask;
            opstore_write_data  = data;
        end else if (kind == KIND_LOAD) begin
            opload_index_valid = 1'b1;
            opload_index       = idx;
        end else begin
            pc_index_valid = 1'b1;
            pc_index       = idx;
        end
    endtask

    // Hold until some ready rises and expect this kind before recording and dropping valid
    task automatic take_request(int kind, ddr_index_t idx, word_t mask, word_t data);
        int n;
        n = 0;
        #1;
        while (!(pc_index_ready || opstore_index_ready || opload_index_ready)) begin
            if (n == TIMEOUT)
                abort_run("Timed out waiting for a request to be accepted");
            @(negedge clk);
            #1;
            n++;
        end
        check_value("channel grant", {pc_index_ready, opstore_index_ready, opload_index_ready},
                    line_t'(1 << kind));
        exp_kind.push_back(kind);
        exp_data.push_back(model_access(kind, idx, mask, data));
        exp_cycle.push_back(cycle_cnt + 1);                   // Count after the accepting edge
        @(negedge clk);
        if (kind == KIND_STORE)
            opstore_index_valid = 1'b0;
        else if (kind == KIND_LOAD)
            opload_index_valid = 1'b0;
        else
            pc_index_valid = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (exp_kind.size() != 0) begin
            if (n == TIMEOUT)
                abort_run("Timed out waiting for an operation done pulse");
            @(posedge clk);
            n++;
        end
        @(negedge clk);                                       // Back on the drive edge
    endtask

    task automatic run_op(int kind, ddr_index_t idx, word_t mask, word_t data);
        drive_request(kind, idx, mask, data);
        take_request(kind, idx, mask, data);
        wait_done();
    endtask

    task automatic end_test(string name);
        $display("Test %-22s %s", name, (fail_cnt == test_fails) ? "passed" : "failed");
        test_fails = fail_cnt;
    endtask

    initial begin
        ddr_index_t idx;
        word_t      store_word;
        void'($urandom(69));
        foreach (ref_mem[i]) ref_mem[i] = '0;
        rst = 1'b1;
        pc_index_valid = 1'b0;
        pc_index = '0;
        opstore_index_valid = 1'b0;
        opstore_index = '0;
        opstore_write_mask = '0;
        opstore_write_data = '0;
        opload_index_valid = 1'b0;
        opload_index = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        #1;                                                   // Idle outputs after reset
        check_value("readies after reset",
                    {pc_index_ready, opstore_index_ready, opload_index_ready}, '0);
        check_value("dones after reset",
                    {pc_operation_done, opstore_operation_done, opload_operation_done}, '0);
        check_value("pc_read_inst after reset", pc_read_inst, '0);
        check_value("opload_read_data after reset", opload_read_data, '0);
        @(negedge clk);
        run_op(KIND_LOAD, ddr_index_t'($urandom), '0, '0);
        end_test("reset state");

        idx = ddr_index_t'($urandom);
        run_op(KIND_STORE, idx, '1, {$urandom, $urandom});
        run_op(KIND_STORE, idx, 64'h00ff_f0f0_0000_ffff, {$urandom, $urandom});
        run_op(KIND_LOAD, idx, '0, '0);
        end_test("masked store then load");

        store_word = {$urandom, $urandom};
        drive_request(KIND_STORE, 19'h00105, '1, store_word);  // All three valid at once
        drive_request(KIND_LOAD, 19'h00105, '0, '0);
        drive_request(KIND_PC, 19'h00102, '0, '0);
        take_request(KIND_STORE, 19'h00105, '1, store_word);
        wait_done();
        take_request(KIND_LOAD, 19'h00105, '0, '0);
        wait_done();
        take_request(KIND_PC, 19'h00102, '0, '0);
        wait_done();
        end_test("priority and latency");

        idx = ddr_index_t'($urandom_range(0, 65535) << 3);    // Line aligned
        for (int i = 0; i < `DDR_LANES; i++)
            run_op(KIND_STORE, idx + ddr_index_t'(i), '1, {$urandom, $urandom});
        run_op(KIND_PC, idx + 19'd5, '0, '0);
        run_op(KIND_PC, idx, '0, '0);
        end_test("burst line read");

        for (int i = 0; i < 200; i++) begin
            idx = ddr_index_t'(($urandom_range(0, 1023) << 9) | $urandom_range(0, 31));
            run_op($urandom_range(0, 2), idx, {$urandom, $urandom}, {$urandom, $urandom});
            repeat ($urandom_range(0, 3)) @(negedge clk);     // Idle gap
        end
        end_test("random operations");

        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsys_top import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // Instruction fetch channel
    input  logic       pc_index_valid,
    input  ddr_index_t pc_index,
    output logic       pc_index_ready,
    output line_t      pc_read_inst,
    output logic       pc_operation_done,

    // Store channel
    input  logic       opstore_index_valid,
    input  ddr_index_t opstore_index,
    input  word_t      opstore_write_mask,
    input  word_t      opstore_write_data,
    output logic       opstore_index_ready,
    output logic       opstore_operation_done,

    // Load channel
    input  logic       opload_index_valid,
    input  ddr_index_t opload_index,
    output logic       opload_index_ready,
    output word_t      opload_read_data,
    output logic       opload_operation_done
);

    // Arbiter to controller
    logic       ddr_ready;
    logic       ddr_chip_enable;
    ddr_index_t ddr_index;
    logic       ddr_write_enable;
    logic       ddr_burst_mode;
    word_t      ddr_opstore_write_mask;
    word_t      ddr_opstore_write_data;

    // Controller to banks and back
    logic  [`DDR_LANES-1:0] bank_en;
    logic  [`DDR_LANES-1:0] bank_we;
    row_t  [`DDR_LANES-1:0] bank_row;
    word_t [`DDR_LANES-1:0] bank_mask;
    word_t [`DDR_LANES-1:0] bank_wdata;
    word_t [`DDR_LANES-1:0] bank_rdata;

    // Completion info
    logic  op_done;
    logic  op_burst;
    logic  op_write;
    lane_t op_lane;

    channel_arb channel_arb_inst (
        .pc_index_valid, .pc_index, .pc_index_ready,
        .opstore_index_valid, .opstore_index, .opstore_write_mask, .opstore_write_data,
        .opstore_index_ready,
        .opload_index_valid, .opload_index, .opload_index_ready,
        .ddr_ready, .ddr_chip_enable, .ddr_index, .ddr_write_enable, .ddr_burst_mode,
        .ddr_opstore_write_mask, .ddr_opstore_write_data
    );

    ddr_ctrl ddr_ctrl_inst (
        .clk, .rst,
        .ddr_chip_enable, .ddr_index, .ddr_write_enable, .ddr_burst_mode,
        .ddr_opstore_write_mask, .ddr_opstore_write_data, .ddr_ready,
        .bank_en, .bank_we, .bank_row, .bank_mask, .bank_wdata,
        .op_done, .op_burst, .op_write, .op_lane
    );

    // One bank per 64-bit lane of a line
    for (genvar i = 0; i < `DDR_LANES; i++) begin : g_bank
        mem_bank mem_bank_inst (
            .clk   (clk),
            .rst   (rst),
            .en    (bank_en[i]),
            .we    (bank_we[i]),
            .row   (bank_row[i]),
            .mask  (bank_mask[i]),
            .wdata (bank_wdata[i]),
            .rdata (bank_rdata[i])
        );
    end

    read_gather read_gather_inst (
        .clk, .rst, .bank_rdata,
        .op_done, .op_burst, .op_write, .op_lane,
        .pc_read_inst, .opload_read_data,
        .pc_operation_done, .opstore_operation_done, .opload_operation_done
    );

endmodule

// File: ddr_ctrl/read_gather.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module read_gather import mem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  word_t [`DDR_LANES-1:0]  bank_rdata,     // Read word of every bank
    input  logic                    op_done,        // Bank data valid now
    input  logic                    op_burst,
    input  logic                    op_write,
    input  lane_t                   op_lane,
    output line_t                   pc_read_inst,
    output word_t                   opload_read_data,
    output logic                    pc_operation_done,
    output logic                    opstore_operation_done,
    output logic                    opload_operation_done
);

    logic load_done;

    assign load_done = op_done && !op_burst && !op_write;   // Plain single read

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_operation_done      <= 1'b0;
            opstore_operation_done <= 1'b0;
            opload_operation_done  <= 1'b0;
            pc_read_inst           <= '0;
            opload_read_data       <= '0;
        end else begin
            pc_operation_done      <= op_done && op_burst;
            opstore_operation_done <= op_done && op_write;
            opload_operation_done  <= load_done;
            if (op_done && op_burst)
                pc_read_inst <= bank_rdata;             // Lane 0 lands in bits 63:0
            if (load_done)
                opload_read_data <= bank_rdata[op_lane];
        end
    end

    // Each completion is reported to exactly one channel
    assert property (@(posedge clk) disable iff (rst)
        op_done |=> $onehot({pc_operation_done, opstore_operation_done, opload_operation_done}))
        else $error("read_gather: done not one-hot");

endmodule

// File: ddr_ctrl/ddr_ctrl.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module ddr_ctrl import mem_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    // Command from the arbiter
    input  logic                    ddr_chip_enable,        // Command valid
    input  ddr_index_t              ddr_index,              // Word index with aliasing upper bits
    input  logic                    ddr_write_enable,       // Store
    input  logic                    ddr_burst_mode,         // Line fetch
    input  word_t                   ddr_opstore_write_mask,
    input  word_t                   ddr_opstore_write_data,
    output logic                    ddr_ready,              // High only in IDLE

    // Bank array
    output logic  [`DDR_LANES-1:0]  bank_en,
    output logic  [`DDR_LANES-1:0]  bank_we,
    output row_t  [`DDR_LANES-1:0]  bank_row,
    output word_t [`DDR_LANES-1:0]  bank_mask,
    output word_t [`DDR_LANES-1:0]  bank_wdata,

    // Completion info for the gatherer
    output logic                    op_done,                // One cycle while bank data is stable
    output logic                    op_burst,
    output logic                    op_write,
    output lane_t                   op_lane
);

    localparam int CNT_BITS = $clog2(`DDR_LATENCY + 1);

    ctrl_state_t         state;
    logic [CNT_BITS-1:0] cnt;                   // Cycles spent in BUSY
    logic                cmd_we;                // Captured kind
    logic                cmd_burst;
    lane_t               cmd_lane;              // Captured address split
    row_t                cmd_row;
    word_t               cmd_mask;              // Captured store payload
    word_t               cmd_wdata;
    logic                accept;
    logic                issue;

    assign accept = (state == IDLE) && ddr_chip_enable;
    assign issue  = (state == BUSY) && (cnt == '0);  // First BUSY cycle drives the banks

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            cnt       <= '0;
            cmd_we    <= 1'b0;
            cmd_burst <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ddr_chip_enable) begin
                        state     <= BUSY;
                        cnt       <= '0;
                        cmd_we    <= ddr_write_enable;
                        cmd_burst <= ddr_burst_mode;
                    end
                end
                BUSY: begin
                    if (cnt == CNT_BITS'(`DDR_LATENCY))
                        state <= IDLE;             // Channel done goes out this cycle
                    else
                        cnt <= cnt + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_lane  <= ddr_index[LANE_BITS-1:0];
            cmd_row   <= ddr_index[LANE_BITS +: `DDR_ROW_BITS];
            cmd_mask  <= ddr_opstore_write_mask;
            cmd_wdata <= ddr_opstore_write_data;
        end
    end

    always_comb begin
        for (int i = 0; i < `DDR_LANES; i++) begin
            bank_en[i]    = issue && (cmd_burst || (cmd_lane == lane_t'(i)));  // All lanes on burst
            bank_we[i]    = bank_en[i] && cmd_we;
            bank_row[i]   = cmd_row;            // Same row in every bank
            bank_mask[i]  = cmd_mask;
            bank_wdata[i] = cmd_wdata;
        end
    end

    assign ddr_ready = (state == IDLE);
    assign op_done   = (state == BUSY) && (cnt == CNT_BITS'(`DDR_LATENCY - 1));
    assign op_burst  = cmd_burst;
    assign op_write  = cmd_we;
    assign op_lane   = cmd_lane;

    // The arbiter must hold off new commands while one is in flight
    assert property (@(posedge clk) disable iff (rst) (state == BUSY) |-> !ddr_chip_enable)
        else $error("ddr_ctrl: command issued while busy");

    // Completion strobe lands a fixed distance after acceptance
    assert property (@(posedge clk) disable iff (rst) accept |-> ##(`DDR_LATENCY) op_done)
        else $error("ddr_ctrl: op_done late or missing");

endmodule

// File: ddr_ctrl/mem_bank.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_bank import mem_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  en,       // Access this cycle
    input  logic  we,       // Write when enabled, else read
    input  row_t  row,
    input  word_t mask,     // 1 marks a bit to replace
    input  word_t wdata,
    output word_t rdata     // Last word read
);

    localparam int DEPTH = 1 << `DDR_ROW_BITS;

    word_t mem [DEPTH];

    // Contents start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (en && we)
            mem[row] <= (mem[row] & ~mask) | (wdata & mask);   // Masked merge
    end

    always_ff @(posedge clk) begin
        if (rst)
            rdata <= '0;
        else if (en && !we)
            rdata <= mem[row];                  // Held until the next read
    end

    // Controller only writes a bank it has selected
    assert property (@(posedge clk) disable iff (rst) we |-> en)
        else $error("mem_bank: write without enable");

endmodule

// File: rtl/channel_arb.sv
`timescale 1ns/1ps

module channel_arb import mem_pkg::*; (
    // Instruction fetch channel
    input  logic       pc_index_valid,          // Fetch request pending
    input  ddr_index_t pc_index,                // Word index inside the wanted line
    output logic       pc_index_ready,          // Fetch request taken this cycle

    // Store channel
    input  logic       opstore_index_valid,     // Store request pending
    input  ddr_index_t opstore_index,           // Word index to write
    input  word_t      opstore_write_mask,      // Bits to replace
    input  word_t      opstore_write_data,      // New word
    output logic       opstore_index_ready,     // Store request taken this cycle

    // Load channel
    input  logic       opload_index_valid,      // Load request pending
    input  ddr_index_t opload_index,            // Word index to read
    output logic       opload_index_ready,      // Load request taken this cycle

    // Command port towards the controller
    input  logic       ddr_ready,               // Controller idle
    output logic       ddr_chip_enable,         // Command valid for one cycle
    output ddr_index_t ddr_index,               // Selected index
    output logic       ddr_write_enable,        // High for a store
    output logic       ddr_burst_mode,          // High for a line fetch
    output word_t      ddr_opstore_write_mask,  // Store mask, zero otherwise
    output word_t      ddr_opstore_write_data   // Store data, zero otherwise
);

    always_comb begin
        ddr_chip_enable        = 1'b0;          // Nothing selected by default
        ddr_index              = '0;
        ddr_write_enable       = 1'b0;
        ddr_burst_mode         = 1'b0;
        ddr_opstore_write_mask = '0;
        ddr_opstore_write_data = '0;
        pc_index_ready         = 1'b0;
        opstore_index_ready    = 1'b0;
        opload_index_ready     = 1'b0;

        if (ddr_ready) begin
            if (opstore_index_valid) begin              // Store wins over everything
                ddr_chip_enable        = 1'b1;
                ddr_index              = opstore_index;
                ddr_write_enable       = 1'b1;
                ddr_opstore_write_mask = opstore_write_mask;
                ddr_opstore_write_data = opstore_write_data;
                opstore_index_ready    = 1'b1;
            end else if (opload_index_valid) begin      // Then the single-word load
                ddr_chip_enable        = 1'b1;
                ddr_index              = opload_index;
                opload_index_ready     = 1'b1;
            end else if (pc_index_valid) begin          // Fetch only when the data side is quiet
                ddr_chip_enable        = 1'b1;
                ddr_index              = pc_index;
                ddr_burst_mode         = 1'b1;
                pc_index_ready         = 1'b1;
            end
        end
    end

    // Only one channel may see its request taken at a time
    always_comb begin
        assert final ($onehot0({pc_index_ready, opstore_index_ready, opload_index_ready}))
            else $error("channel_arb: more than one ready high");
    end

endmodule

// File: common/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

    localparam int WORD_BITS = 64;                          // Width of one bank word
    localparam int LANE_BITS = $clog2(`DDR_LANES);          // Index bits that pick the bank

    typedef logic [18:0] ddr_index_t;                       // Word address from a channel
    typedef logic [WORD_BITS-1:0] word_t;                   // Data word or per-bit mask
    typedef logic [`DDR_LANES*WORD_BITS-1:0] line_t;        // Burst line, lane 0 in low bits
    typedef logic [LANE_BITS-1:0] lane_t;                   // Bank select
    typedef logic [`DDR_ROW_BITS-1:0] row_t;                // Row inside one bank

    // Controller FSM
    typedef enum logic {
        IDLE,                                               // Waiting for a command
        BUSY                                                // Command in flight
    } ctrl_state_t;

endpackage

// File: common/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Banks in the array, also 64-bit words per burst line
`define DDR_LANES 8

// Log2 of the bank depth
`define DDR_ROW_BITS 6

// Cycles from acceptance to the channel done pulse, 2 at least
`define DDR_LATENCY 3

`endif
